/* vlog.f */
+incdir+verilog
+incdir+verification
verilog/cache_pkg.sv
verilog/cache_request_in.sv
verilog/cache_tag_store.sv
verilog/cache_meta_store.sv
verilog/cache_way_select.sv
verilog/cache_data_store.sv
verilog/cache_response_out.sv
verilog/cache_stage1.sv
verification/tb_cache_stage1.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cache_stage1
RTL_TOP    := cache_stage1
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulation output
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_cache_table.svh */
`ifndef TB_CACHE_TABLE_SVH
`define TB_CACHE_TABLE_SVH

// Columns: op, address {tag, index, offset}, mask selector, mshr_full,
// expected hit, expected miss, expected writeback

localparam int NUM_ROWS = 27;

localparam row_t ROWS [NUM_ROWS] = '{
    // --------------------
    // Cold miss, fill, hit, masked write
    // --------------------
    '{cache_pkg::OP_READ,  {8'ha1, 2'd1, 5'd0}, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0},
    '{cache_pkg::OP_FILL,  {8'ha1, 2'd1, 5'd0}, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{cache_pkg::OP_READ,  {8'ha1, 2'd1, 5'd0}, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0},
    '{cache_pkg::OP_WRITE, {8'ha1, 2'd1, 5'd0}, 2'd1, 1'b0, 1'b1, 1'b0, 1'b0},
    '{cache_pkg::OP_READ,  {8'ha1, 2'd1, 5'd0}, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0},
    // --------------------
    // Five tags into set 2
    // --------------------
    '{cache_pkg::OP_FILL,  {8'hb0, 2'd2, 5'd0}, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{cache_pkg::OP_FILL,  {8'hb1, 2'd2, 5'd0}, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{cache_pkg::OP_WRITE, {8'hb0, 2'd2, 5'd0}, 2'd2, 1'b0, 1'b1, 1'b0, 1'b0},
    '{cache_pkg::OP_FILL,  {8'hb2, 2'd2, 5'd0}, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{cache_pkg::OP_FILL,  {8'hb3, 2'd2, 5'd0}, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{cache_pkg::OP_FILL,  {8'hb4, 2'd2, 5'd0}, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
    // B1 was evicted, dirty B0 is now oldest
    '{cache_pkg::OP_READ,  {8'hb1, 2'd2, 5'd0}, 2'd0, 1'b0, 1'b0, 1'b1, 1'b1},
    '{cache_pkg::OP_READ,  {8'hb4, 2'd2, 5'd0}, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0},
    // --------------------
    // Misses with the MSHRs full
    // --------------------
    '{cache_pkg::OP_WRITE, {8'hc5, 2'd3, 5'd0}, 2'd0, 1'b1, 1'b0, 1'b1, 1'b0},
    '{cache_pkg::OP_READ,  {8'hc5, 2'd3, 5'd0}, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0},
    '{cache_pkg::OP_READ,  {8'hb1, 2'd2, 5'd0}, 2'd0, 1'b1, 1'b0, 1'b1, 1'b1},
    // Back to back, read right after write
    '{cache_pkg::OP_FILL,  {8'hc5, 2'd3, 5'd0}, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{cache_pkg::OP_WRITE, {8'hc5, 2'd3, 5'd0}, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0},
    '{cache_pkg::OP_READ,  {8'hc5, 2'd3, 5'd0}, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0},
    '{cache_pkg::OP_FILL,  {8'ha2, 2'd1, 5'd0}, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{cache_pkg::OP_READ,  {8'ha1, 2'd1, 5'd0}, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0},
    '{cache_pkg::OP_WRITE, {8'ha2, 2'd1, 5'd0}, 2'd3, 1'b0, 1'b1, 1'b0, 1'b0},
    '{cache_pkg::OP_READ,  {8'ha2, 2'd1, 5'd0}, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0},
    // Full MSHRs stall only a miss
    '{cache_pkg::OP_READ,  {8'ha3, 2'd1, 5'd0}, 2'd0, 1'b1, 1'b0, 1'b1, 1'b0},
    '{cache_pkg::OP_READ,  {8'ha1, 2'd1, 5'd0}, 2'd0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{cache_pkg::OP_FILL,  {8'hd0, 2'd0, 5'd0}, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{cache_pkg::OP_READ,  {8'hd0, 2'd0, 5'd0}, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0}
};

`endif

/* verification/tb_cache_stage1.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module tb_cache_stage1;

    typedef struct packed {
        cache_pkg::cache_op_t op;
        cache_pkg::paddr_t    addr;
        logic [1:0]           mask_sel;
        logic                 mshr_full;
        logic                 hit;
        logic                 miss;
        logic                 writeback;
    } row_t;

    typedef struct packed {
        logic [7:0]        row;
        logic              hit;
        logic              miss;
        logic              writeback;
        cache_pkg::paddr_t ext_address;
        cache_pkg::line_t  line;
    } expect_t;

    `include "tb_cache_table.svh"

    localparam int CLK_PERIOD   = 100;
    localparam int STALL_CYCLES = 3;

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    cache_pkg::cache_op_t  req_op;
    cache_pkg::paddr_t     paddr;
    cache_pkg::line_t      data;
    cache_pkg::mask_t      mask;
    logic                  mshr_full;
    logic                  stall;
    cache_pkg::cache_rsp_t rsp;

    // Reference model of the arrays
    logic                 m_valid [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::tag_t      m_tag   [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::lru_rank_t m_rank  [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::line_t     m_line  [`CACHE_SETS][`CACHE_WAYS];

    expect_t     expected_q [$];
    logic [31:0] lfsr_state = 32'h7e14;

    cache_stage1 uut (
        .clk, .reset, .req_valid, .req_op, .paddr, .data, .mask, .mshr_full, .stall, .rsp
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Failure reporting
    // --------------------

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] want);
        $display("ERR %0t %s got %h expected %h", $time, name, got, want);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped at %0t: %s", $time, why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_line(output cache_pkg::line_t l);
        for (int b = 0; b < `LINE_BITS; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            l[b] = lfsr_state[0];
        end
    endtask

    function automatic cache_pkg::mask_t mask_for(input logic [1:0] sel);
        case (sel)
            2'd0: return '1;
            2'd1: return {{64{1'b0}}, {64{1'b1}}};
            2'd2: return {16{8'hf0}};
            default: return {32{4'h5}};
        endcase
    endfunction

    // Touched way becomes newest
    task automatic touch_lru(input cache_pkg::index_t s, input int way);
        cache_pkg::lru_rank_t old;
        old = m_rank[s][way];
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (w == way) begin
                m_rank[s][w] = '0;
            end else if (m_rank[s][w] < old) begin
                m_rank[s][w] = m_rank[s][w] + 1'b1;
            end
        end
    endtask

    task automatic predict(input row_t r, input int idx, input cache_pkg::line_t wdata,
                           input cache_pkg::mask_t wmask);
        cache_pkg::tag_t   t;
        cache_pkg::index_t s;
        int                way;
        logic              found;
        expect_t           e;
        t = r.addr[`PADDR_BITS-1 -: `TAG_BITS];
        s = r.addr[`INDEX_LSB +: 2];
        way = -1;
        for (int w = 0; w < `CACHE_WAYS && way < 0; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                way = w;
            end
        end
        found = way >= 0;
        // Victim is the lowest free way, else the oldest
        for (int w = 0; w < `CACHE_WAYS && way < 0; w++) begin
            if (!m_valid[s][w]) begin
                way = w;
            end
        end
        for (int w = 0; w < `CACHE_WAYS && way < 0; w++) begin
            if (m_rank[s][w] == 2'd3) begin
                way = w;
            end
        end
        e.row = 8'(idx);
        e.hit = r.hit;
        e.miss = r.miss;
        e.writeback = r.writeback;
        e.ext_address = {t, s, {`INDEX_LSB{1'b0}}};
        if (r.op == cache_pkg::OP_FILL) begin
            m_line[s][way] = wdata;
            m_valid[s][way] = 1'b1;
            m_tag[s][way] = t;
            touch_lru(s, way);
        end else if (found) begin
            if (r.op == cache_pkg::OP_WRITE) begin
                m_line[s][way] = (m_line[s][way] & ~wmask) | (wdata & wmask);
            end
            touch_lru(s, way);
        end else begin
            e.ext_address = {m_tag[s][way], s, {`INDEX_LSB{1'b0}}};
        end
        e.line = m_line[s][way];
        expected_q.push_back(e);
    endtask

    task automatic apply_row(input int idx);
        row_t             r;
        cache_pkg::line_t wdata;
        cache_pkg::mask_t wmask;
        r = ROWS[idx];
        wdata = '0;
        wmask = '0;
        if (r.op != cache_pkg::OP_READ) begin
            random_line(wdata);
        end
        if (r.op == cache_pkg::OP_WRITE) begin
            wmask = mask_for(r.mask_sel);
        end
        req_valid = 1'b1;
        req_op = r.op;
        paddr = r.addr;
        data = wdata;
        mask = wmask;
        predict(r, idx, wdata, wmask);
    endtask

    // --------------------
    // Response checks
    // --------------------

    task automatic check_response();
        expect_t e;
        assert (expected_q.size() > 0) else abort_run("response arrived with no request pending");
        e = expected_q.pop_front();
        assert (rsp.hit === e.hit)
            else report_mismatch($sformatf("rsp.hit row %0d", e.row), rsp.hit, e.hit);
        assert (rsp.miss === e.miss)
            else report_mismatch($sformatf("rsp.miss row %0d", e.row), rsp.miss, e.miss);
        assert (rsp.writeback === e.writeback)
            else report_mismatch($sformatf("rsp.writeback row %0d", e.row),
                                 rsp.writeback, e.writeback);
        assert (rsp.ext_address === e.ext_address)
            else report_mismatch($sformatf("rsp.ext_address row %0d", e.row),
                                 rsp.ext_address, e.ext_address);
        assert (rsp.line === e.line)
            else report_mismatch($sformatf("rsp.line row %0d", e.row), rsp.line, e.line);
    endtask

    always @(negedge clk) begin
        if (rsp.valid === 1'b1) begin
            check_response();
        end
    end

    initial begin
        #((NUM_ROWS + 20) * 4 * CLK_PERIOD);
        abort_run("watchdog expired before all responses arrived");
    end

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        logic expect_stall;
        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req_op = cache_pkg::OP_READ;
        paddr = '0;
        data = '0;
        mask = '0;
        mshr_full = 1'b0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w] = '0;
                m_line[s][w] = '0;
                m_rank[s][w] = cache_pkg::lru_rank_t'(w);
            end
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;

        // Row i-1 is in lookup while row i waits at the inputs
        for (int i = 0; i <= NUM_ROWS; i++) begin
            @(negedge clk);
            mshr_full = (i > 0) ? ROWS[i-1].mshr_full : 1'b0;
            if (i < NUM_ROWS) begin
                apply_row(i);
            end else begin
                req_valid = 1'b0;
            end
            expect_stall = (i > 0) && ROWS[i-1].mshr_full && ROWS[i-1].miss;
            #1;
            assert (stall === expect_stall) else report_mismatch("stall", stall, expect_stall);
            if (expect_stall) begin
                repeat (STALL_CYCLES) begin
                    @(negedge clk);
                    assert (stall === 1'b1 && rsp.valid === 1'b0)
                        else abort_run("stalled miss did not hold the stage");
                end
                mshr_full = 1'b0;
            end
        end

        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        #1;
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cache_stage1.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module cache_stage1 (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   req_valid,
    input  wire cache_pkg::cache_op_t   req_op,
    input  wire cache_pkg::paddr_t      paddr,
    input  wire cache_pkg::line_t       data,
    input  wire cache_pkg::mask_t       mask,
    input  wire logic                   mshr_full,
    output logic                        stall,
    output cache_pkg::cache_rsp_t       rsp
);

    cache_pkg::cache_req_t                   stage_req;
    cache_pkg::way_vec_t                     hits;
    cache_pkg::way_vec_t                     valid_bits;
    cache_pkg::way_vec_t                     dirty_bits;
    cache_pkg::tag_t [`CACHE_WAYS-1:0]       set_tags;
    cache_pkg::lru_rank_t [`CACHE_WAYS-1:0]  ranks;
    cache_pkg::way_t                         sel_way;
    cache_pkg::line_t                        sel_line;
    cache_pkg::line_t                        new_line;
    cache_pkg::tag_t                         victim_tag;
    logic hit;
    logic miss;
    logic writeback;
    logic tag_write;
    logic data_write;
    logic meta_update;
    logic set_dirty;

    assign victim_tag = set_tags[sel_way];

    cache_request_in u_request_in (
        .clk, .reset, .req_valid, .req_op, .paddr, .data, .mask, .stall, .stage_req
    );

    cache_tag_store u_tag_store (
        .clk, .reset, .stage_req, .sel_way, .tag_write, .hits, .valid_bits, .set_tags
    );

    cache_meta_store u_meta_store (
        .clk, .reset, .stage_req, .sel_way, .meta_update, .set_dirty, .dirty_bits, .ranks
    );

    cache_way_select u_way_select (
        .stage_req, .mshr_full, .hits, .valid_bits, .dirty_bits, .ranks, .sel_way,
        .hit, .miss, .writeback, .stall, .tag_write, .data_write, .meta_update, .set_dirty
    );

    cache_data_store u_data_store (
        .clk, .reset, .stage_req, .sel_way, .data_write, .sel_line, .new_line
    );

    cache_response_out u_response_out (
        .clk, .reset, .stage_req, .stall, .hit, .miss, .writeback,
        .sel_line, .new_line, .victim_tag, .rsp
    );

endmodule

`default_nettype wire

/* verilog/cache_response_out.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module cache_response_out (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire cache_pkg::cache_req_t  stage_req,
    input  wire logic                   stall,
    input  wire logic                   hit,
    input  wire logic                   miss,
    input  wire logic                   writeback,
    input  wire cache_pkg::line_t       sel_line,
    input  wire cache_pkg::line_t       new_line,
    input  wire cache_pkg::tag_t        victim_tag,
    output cache_pkg::cache_rsp_t       rsp
);

    cache_pkg::paddr_t ext_address;
    cache_pkg::line_t  rsp_line;
    logic              use_new;

    // Write hits and fills return the updated line
    assign use_new  = stage_req.op == cache_pkg::OP_FILL
                   || (hit && stage_req.op == cache_pkg::OP_WRITE);
    assign rsp_line = use_new ? new_line : sel_line;

    // Victim line address on a miss
    assign ext_address = {miss ? victim_tag : stage_req.tag, stage_req.index,
                          {`INDEX_LSB{1'b0}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp.valid     <= 1'b0;
            rsp.hit       <= 1'b0;
            rsp.miss      <= 1'b0;
            rsp.writeback <= 1'b0;
        end else begin
            rsp.valid     <= stage_req.valid && !stall;
            rsp.hit       <= hit;
            rsp.miss      <= miss;
            rsp.writeback <= writeback;
        end
        rsp.ext_address <= ext_address;
        rsp.line        <= rsp_line;
    end

endmodule

`default_nettype wire

/* verilog/cache_data_store.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module cache_data_store (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire cache_pkg::cache_req_t  stage_req,
    input  wire cache_pkg::way_t        sel_way,
    input  wire logic                   data_write,
    output cache_pkg::line_t            sel_line,
    output cache_pkg::line_t            new_line
);

    cache_pkg::line_t lines_q [`CACHE_SETS][`CACHE_WAYS];

    // --------------------
    // Read and merge
    // --------------------

    assign sel_line = lines_q[stage_req.index][sel_way];

    // Fills replace the line, writes take only masked bits
    always_comb begin
        if (stage_req.op == cache_pkg::OP_FILL) begin
            new_line = stage_req.data;
        end else begin
            new_line = (sel_line & ~stage_req.mask) | (stage_req.data & stage_req.mask);
        end
    end

    // --------------------
    // Line array
    // --------------------

    // No line writes while in reset
    always_ff @(posedge clk) begin
        if (data_write && !reset) begin
            lines_q[stage_req.index][sel_way] <= new_line;
        end
    end

endmodule

`default_nettype wire

/* verilog/cache_way_select.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module cache_way_select (
    input  wire cache_pkg::cache_req_t  stage_req,
    input  wire logic                   mshr_full,
    input  wire cache_pkg::way_vec_t    hits,
    input  wire cache_pkg::way_vec_t    valid_bits,
    input  wire cache_pkg::way_vec_t    dirty_bits,
    input  wire cache_pkg::lru_rank_t [`CACHE_WAYS-1:0] ranks,
    output cache_pkg::way_t             sel_way,
    output logic                        hit,
    output logic                        miss,
    output logic                        writeback,
    output logic                        stall,
    output logic                        tag_write,
    output logic                        data_write,
    output logic                        meta_update,
    output logic                        set_dirty
);

    cache_pkg::way_t hit_way;
    cache_pkg::way_t victim_way;
    logic            any_hit;
    logic            is_fill;
    logic            is_write;

    assign any_hit  = |hits;
    assign is_fill  = stage_req.op == cache_pkg::OP_FILL;
    assign is_write = stage_req.op == cache_pkg::OP_WRITE;

    // --------------------
    // Way choice
    // --------------------

    always_comb begin
        hit_way = '0;
        for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
            if (hits[w]) begin
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    // Oldest way first, then overridden by the lowest invalid way
    always_comb begin
        victim_way = '0;
        for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
            if (ranks[w] == cache_pkg::lru_rank_t'(`CACHE_WAYS-1)) begin
                victim_way = cache_pkg::way_t'(w);
            end
        end
        for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
            if (!valid_bits[w]) begin
                victim_way = cache_pkg::way_t'(w);
            end
        end
    end

    assign sel_way = any_hit ? hit_way : victim_way;

    // --------------------
    // Flags and strobes
    // --------------------

    assign hit       = stage_req.valid && !is_fill && any_hit;
    assign miss      = stage_req.valid && !is_fill && !any_hit;
    assign writeback = miss && valid_bits[sel_way] && dirty_bits[sel_way];
    assign stall     = miss && mshr_full;

    assign tag_write   = stage_req.valid && is_fill && !stall;
    assign data_write  = stage_req.valid && (is_fill || (is_write && any_hit)) && !stall;
    assign meta_update = stage_req.valid && (is_fill || any_hit) && !stall;

    // Read hits keep the current dirty bit
    assign set_dirty = is_fill ? 1'b0 : (is_write ? 1'b1 : dirty_bits[sel_way]);

endmodule

`default_nettype wire

/* verilog/cache_meta_store.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module cache_meta_store (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire cache_pkg::cache_req_t  stage_req,
    input  wire cache_pkg::way_t        sel_way,
    input  wire logic                   meta_update,
    input  wire logic                   set_dirty,
    output cache_pkg::way_vec_t         dirty_bits,
    output cache_pkg::lru_rank_t [`CACHE_WAYS-1:0] ranks
);

    cache_pkg::way_vec_t                     dirty_q [`CACHE_SETS];
    cache_pkg::lru_rank_t [`CACHE_WAYS-1:0]  ranks_q [`CACHE_SETS];
    cache_pkg::lru_rank_t                    old_rank;

    // --------------------
    // Set read
    // --------------------

    assign dirty_bits = dirty_q[stage_req.index];
    assign ranks      = ranks_q[stage_req.index];

    // Rank of the way being touched
    assign old_rank = ranks[sel_way];

    // --------------------
    // Update
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                dirty_q[s] <= '0;
                // Way number doubles as starting rank
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    ranks_q[s][w] <= cache_pkg::lru_rank_t'(w);
                end
            end
        end else if (meta_update) begin
            // Touched way becomes newest, younger ways age by one
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (cache_pkg::way_t'(w) == sel_way) begin
                    ranks_q[stage_req.index][w] <= '0;
                end else if (ranks[w] < old_rank) begin
                    ranks_q[stage_req.index][w] <= ranks[w] + 1'b1;
                end
            end
            dirty_q[stage_req.index][sel_way] <= set_dirty;
        end
    end

endmodule

`default_nettype wire

/* verilog/cache_tag_store.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module cache_tag_store (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire cache_pkg::cache_req_t  stage_req,
    input  wire cache_pkg::way_t        sel_way,
    input  wire logic                   tag_write,
    output cache_pkg::way_vec_t         hits,
    output cache_pkg::way_vec_t         valid_bits,
    output cache_pkg::tag_t [`CACHE_WAYS-1:0] set_tags
);

    cache_pkg::tag_t [`CACHE_WAYS-1:0] tags_q  [`CACHE_SETS];
    cache_pkg::way_vec_t               valid_q [`CACHE_SETS];

    // --------------------
    // Set read
    // --------------------

    assign set_tags   = tags_q[stage_req.index];
    assign valid_bits = valid_q[stage_req.index];

    // Four-way compare, invalid ways never hit
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hits[w] = valid_bits[w] && (set_tags[w] == stage_req.tag);
        end
    end

    // --------------------
    // Update
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (tag_write) begin
            valid_q[stage_req.index][sel_way] <= 1'b1;
        end
    end

    // Tag array itself
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tags_q[s] <= '0;
            end
        end else if (tag_write) begin
            tags_q[stage_req.index][sel_way] <= stage_req.tag;
        end
    end

endmodule

`default_nettype wire

/* verilog/cache_request_in.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module cache_request_in (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  req_valid,
    input  wire cache_pkg::cache_op_t  req_op,
    input  wire cache_pkg::paddr_t     paddr,
    input  wire cache_pkg::line_t      data,
    input  wire cache_pkg::mask_t      mask,
    input  wire logic                  stall,
    output cache_pkg::cache_req_t      stage_req
);

    cache_pkg::tag_t   req_tag;
    cache_pkg::index_t req_index;

    // Address split
    assign req_tag   = paddr[`PADDR_BITS-1 -: `TAG_BITS];
    assign req_index = paddr[`INDEX_LSB +: $bits(cache_pkg::index_t)];

    // --------------------
    // Stage register
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_req.valid <= 1'b0;
        end else if (!stall) begin
            stage_req.valid <= req_valid;
        end

        // Payload held while stalled
        if (!stall) begin
            stage_req.op    <= req_op;
            stage_req.tag   <= req_tag;
            stage_req.index <= req_index;
            stage_req.data  <= data;
            stage_req.mask  <= mask;
        end
    end

endmodule

`default_nettype wire

/* verilog/cache_pkg.sv */
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    // --------------------
    // Vector types
    // --------------------

    typedef logic [`PADDR_BITS-1:0]           paddr_t;
    typedef logic [`TAG_BITS-1:0]             tag_t;
    typedef logic [$clog2(`CACHE_SETS)-1:0]   index_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0]   way_t;
    typedef logic [`CACHE_WAYS-1:0]           way_vec_t;

    // Age rank, 0 newest
    typedef logic [$clog2(`CACHE_WAYS)-1:0]   lru_rank_t;

    typedef logic [`LINE_BITS-1:0]            line_t;
    typedef logic [`LINE_BITS-1:0]            mask_t;

    // --------------------
    // Request and response
    // --------------------

    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_FILL  = 2'd2
    } cache_op_t;

    typedef struct packed {
        logic      valid;
        cache_op_t op;
        tag_t      tag;
        index_t    index;
        line_t     data;
        mask_t     mask;
    } cache_req_t;

    typedef struct packed {
        logic   valid;
        logic   hit;
        logic   miss;
        logic   writeback;
        paddr_t ext_address;
        line_t  line;
    } cache_rsp_t;

endpackage

`default_nettype wire

/* verilog/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// --------------------
// Cache geometry
// --------------------

`define CACHE_WAYS 4
`define CACHE_SETS 4

// Tag sits above the set index, line offset below it
`define TAG_BITS  8
`define INDEX_LSB 5

// --------------------
// Data and address widths
// --------------------

`define LINE_BITS  128
`define PADDR_BITS 15

`endif
